// ==== source/datamem_pkg.sv ====
`default_nettype none

package datamem_pkg;

	// Data word and its byte lanes
	localparam int word_bits = 32;
	localparam int lane_count = 4;

	// Core address widths
	localparam int word_addr_bits = 11;
	localparam int byte_addr_bits = 13;

	// Board I/O registers, word addresses
	// Base sits on a 4-word boundary so the low two bits index the registers
	localparam logic [word_addr_bits-1:0] io_btn_addr = 11'h400;
	localparam logic [word_addr_bits-1:0] io_sw_addr = 11'h401;
	localparam logic [word_addr_bits-1:0] io_led_addr = 11'h402;

	// Access size, funct3 bits 1:0
	localparam logic [1:0] mem_size_byte = 2'd0;
	localparam logic [1:0] mem_size_half = 2'd1;
	localparam logic [1:0] mem_size_word = 2'd2;

endpackage

`default_nettype wire

// ==== source/dp_blockram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dp_blockram #(
	parameter int ram_addr_bits = 10
) (
	input wire logic clk,

	// Port A, core side
	input wire logic [datamem_pkg::lane_count-1:0] a_we,
	input wire logic [ram_addr_bits-1:0] a_addr,
	input wire logic [datamem_pkg::word_bits-1:0] a_din,
	output logic [datamem_pkg::word_bits-1:0] a_dout,

	// Port B, protocol controller side
	input wire logic [datamem_pkg::lane_count-1:0] b_we,
	input wire logic [ram_addr_bits-1:0] b_addr,
	input wire logic [datamem_pkg::word_bits-1:0] b_din,
	output logic [datamem_pkg::word_bits-1:0] b_dout
);

	localparam int lane_bits = datamem_pkg::word_bits / datamem_pkg::lane_count;
	localparam int depth = 2 ** ram_addr_bits;

	// Storage array, contents undefined after power-up
	logic [datamem_pkg::word_bits-1:0] mem [0:depth-1];

	always_ff @(posedge clk) begin
		// Per-lane writes on both ports
		// Same word from both ports in one cycle is undefined, B lands last here
		for (int i = 0; i < datamem_pkg::lane_count; i++) begin
			if (a_we[i]) begin
				mem[a_addr][i*lane_bits +: lane_bits] <= a_din[i*lane_bits +: lane_bits];
			end
			if (b_we[i]) begin
				mem[b_addr][i*lane_bits +: lane_bits] <= b_din[i*lane_bits +: lane_bits];
			end
		end

		// Registered reads see the word before this edge's write
		a_dout <= mem[a_addr];
		b_dout <= mem[b_addr];
	end

endmodule

`default_nettype wire

// ==== source/fpgaio_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpgaio_regs (
	input wire logic clk,
	input wire logic nrst,

	// Board pins
	input wire logic [3:0] btn,
	input wire logic [2:0] sw,

	// LED write lanes, already qualified by address
	input wire logic [datamem_pkg::lane_count-1:0] led_we,
	input wire logic [datamem_pkg::word_bits-1:0] wdata,

	// Register index, 0 buttons, 1 switches, 2 LEDs
	input wire logic [1:0] rd_addr,
	output logic [datamem_pkg::word_bits-1:0] rdata,

	output logic [3:0] led
);

	localparam int lane_bits = datamem_pkg::word_bits / datamem_pkg::lane_count;

	logic [3:0] btn_q;
	logic [2:0] sw_q;
	logic [datamem_pkg::word_bits-1:0] led_q;

	// Sample board inputs every edge
	always_ff @(posedge clk) begin
		if (!nrst) begin
			btn_q <= '0;
			sw_q <= '0;
		end else begin
			btn_q <= btn;
			sw_q <= sw;
		end
	end

	// LED word, merge only the enabled lanes
	always_ff @(posedge clk) begin
		if (!nrst) begin
			led_q <= '0;
		end else begin
			for (int i = 0; i < datamem_pkg::lane_count; i++) begin
				if (led_we[i]) begin
					led_q[i*lane_bits +: lane_bits] <= wdata[i*lane_bits +: lane_bits];
				end
			end
		end
	end

	// Only the low nibble reaches the board
	assign led = led_q[3:0];

	// Read mux
	always_comb begin
		case (rd_addr)
			2'd0: rdata = {{(datamem_pkg::word_bits-4){1'b0}}, btn_q};
			2'd1: rdata = {{(datamem_pkg::word_bits-3){1'b0}}, sw_q};
			2'd2: rdata = led_q;
			// Unused slot in the window
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/datamem.sv ====
`timescale 1ns/1ps
`default_nettype none

module datamem #(
	parameter int ram_addr_bits = 10
) (
	input wire logic clk,
	input wire logic nrst,

	// Core side
	input wire logic [datamem_pkg::lane_count-1:0] dm_write,
	input wire logic [datamem_pkg::word_addr_bits-1:0] exe_data_addr,
	input wire logic [datamem_pkg::word_addr_bits-1:0] mem_data_addr,
	input wire logic [datamem_pkg::word_bits-1:0] data_in,

	// Board I/O
	input wire logic [3:0] btn,
	input wire logic [2:0] sw,
	output logic [3:0] led,

	// Protocol controller, RAM only
	input wire logic [datamem_pkg::lane_count-1:0] con_write,
	input wire logic [ram_addr_bits-1:0] con_addr,
	input wire logic [datamem_pkg::word_bits-1:0] con_in,

	output logic [datamem_pkg::word_bits-1:0] data_out,
	output logic [datamem_pkg::word_bits-1:0] con_out
);

	logic [datamem_pkg::lane_count-1:0] ram_we;
	logic [datamem_pkg::lane_count-1:0] led_we;
	logic [datamem_pkg::word_bits-1:0] ram_dout;
	logic [datamem_pkg::word_bits-1:0] io_rdata;
	logic io_read;

	// RAM takes writes only below the I/O window
	assign ram_we = (exe_data_addr < datamem_pkg::io_btn_addr) ? dm_write : '0;

	// Buttons and switches are read-only
	assign led_we = (exe_data_addr == datamem_pkg::io_led_addr) ? dm_write : '0;

	// Port A is addressed in execute so its data lands in the memory stage
	dp_blockram #(
		.ram_addr_bits(ram_addr_bits)
	) u_ram (
		.clk(clk),
		.a_we(ram_we),
		.a_addr(exe_data_addr[ram_addr_bits-1:0]),
		.a_din(data_in),
		.a_dout(ram_dout),
		.b_we(con_write),
		.b_addr(con_addr),
		.b_din(con_in),
		.b_dout(con_out)
	);

	// Window base is 4-word aligned, low bits pick the register
	fpgaio_regs u_io (
		.clk(clk),
		.nrst(nrst),
		.btn(btn),
		.sw(sw),
		.led_we(led_we),
		.wdata(data_in),
		.rd_addr(mem_data_addr[1:0]),
		.rdata(io_rdata),
		.led(led)
	);

	// Read select uses the memory stage address
	assign io_read = (mem_data_addr >= datamem_pkg::io_btn_addr);
	assign data_out = io_read ? io_rdata : ram_dout;

endmodule

`default_nettype wire

// ==== source/store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_unit (
	input wire logic exe_store,
	input wire logic [1:0] exe_size,
	input wire logic [1:0] byte_offset,
	input wire logic [datamem_pkg::word_bits-1:0] exe_wdata,
	output logic [datamem_pkg::lane_count-1:0] dm_write,
	output logic [datamem_pkg::word_bits-1:0] data_in
);

	localparam int lane_bits = datamem_pkg::word_bits / datamem_pkg::lane_count;
	localparam int half_bits = 2 * lane_bits;

	logic [datamem_pkg::lane_count-1:0] lanes;

	always_comb begin
		lanes = '0;
		data_in = exe_wdata;
		case (exe_size)
			datamem_pkg::mem_size_byte: begin
				// Byte copied into every lane, one lane enabled
				data_in = {datamem_pkg::lane_count{exe_wdata[lane_bits-1:0]}};
				lanes[byte_offset] = 1'b1;
			end
			datamem_pkg::mem_size_half: begin
				// Half copied into both halves
				data_in = {2{exe_wdata[half_bits-1:0]}};
				// Odd offset drops the store
				if (!byte_offset[0]) begin
					lanes = byte_offset[1] ? 4'b1100 : 4'b0011;
				end
			end
			datamem_pkg::mem_size_word: begin
				// Word only at offset 0
				if (byte_offset == 2'd0) begin
					lanes = '1;
				end
			end
			default: begin
				// No 64-bit access on RV32, nothing written
				lanes = '0;
			end
		endcase
	end

	// Lanes only while the strobe is up
	assign dm_write = exe_store ? lanes : '0;

endmodule

`default_nettype wire

// ==== source/load_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_unit (
	input wire logic clk,
	input wire logic nrst,

	// Execute stage request
	input wire logic exe_load,
	input wire logic [datamem_pkg::byte_addr_bits-1:0] exe_addr,
	input wire logic [1:0] exe_size,
	input wire logic exe_unsigned,

	// Memory stage word address and returned word
	output logic [datamem_pkg::word_addr_bits-1:0] mem_data_addr,
	input wire logic [datamem_pkg::word_bits-1:0] data_out,

	// Result to the core
	output logic load_valid,
	output logic [datamem_pkg::word_bits-1:0] load_data,
	output logic load_misaligned
);

	localparam int lane_bits = datamem_pkg::word_bits / datamem_pkg::lane_count;
	localparam int half_bits = 2 * lane_bits;

	logic mem_load;
	logic [1:0] mem_offset;
	logic [1:0] mem_size;
	logic mem_unsigned;
	logic misaligned;
	logic fill;
	logic [datamem_pkg::word_bits-1:0] shifted;
	logic [datamem_pkg::word_bits-1:0] extended;

	// Load strobe into the memory stage
	always_ff @(posedge clk) begin
		if (!nrst) begin
			mem_load <= 1'b0;
		end else begin
			mem_load <= exe_load;
		end
	end

	// Load attributes follow every edge
	always_ff @(posedge clk) begin
		mem_data_addr <= exe_addr[datamem_pkg::byte_addr_bits-1:2];
		mem_offset <= exe_addr[1:0];
		mem_size <= exe_size;
		mem_unsigned <= exe_unsigned;
	end

	// Alignment check on the memory stage attributes
	always_comb begin
		case (mem_size)
			datamem_pkg::mem_size_byte: misaligned = 1'b0;
			datamem_pkg::mem_size_half: misaligned = mem_offset[0];
			datamem_pkg::mem_size_word: misaligned = |mem_offset;
			// Size 3 has no legal alignment
			default: misaligned = 1'b1;
		endcase
	end

	// Bring the addressed byte or half down to bit 0
	assign shifted = data_out >> {mem_offset, 3'b000};

	always_comb begin
		fill = 1'b0;
		case (mem_size)
			datamem_pkg::mem_size_byte: begin
				fill = ~mem_unsigned & shifted[lane_bits-1];
				extended = {{(datamem_pkg::word_bits-lane_bits){fill}},
					shifted[lane_bits-1:0]};
			end
			datamem_pkg::mem_size_half: begin
				fill = ~mem_unsigned & shifted[half_bits-1];
				extended = {{(datamem_pkg::word_bits-half_bits){fill}},
					shifted[half_bits-1:0]};
			end
			default: extended = data_out;
		endcase
	end

	// Exactly one of the two flags per memory stage load
	assign load_valid = mem_load & ~misaligned;
	assign load_misaligned = mem_load & misaligned;

	// Zero whenever no good load is presented
	assign load_data = load_valid ? extended : '0;

endmodule

`default_nettype wire

// ==== source/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem #(
	parameter int ram_addr_bits = 10
) (
	input wire logic clk,
	input wire logic nrst,

	// Core requests
	input wire logic [datamem_pkg::byte_addr_bits-1:0] exe_addr,
	input wire logic exe_store,
	input wire logic exe_load,
	input wire logic [1:0] exe_size,
	input wire logic exe_unsigned,
	input wire logic [datamem_pkg::word_bits-1:0] exe_wdata,

	// Load results
	output logic load_valid,
	output logic [datamem_pkg::word_bits-1:0] load_data,
	output logic load_misaligned,

	// Protocol controller port
	input wire logic [datamem_pkg::lane_count-1:0] con_write,
	input wire logic [ram_addr_bits-1:0] con_addr,
	input wire logic [datamem_pkg::word_bits-1:0] con_in,
	output logic [datamem_pkg::word_bits-1:0] con_out,

	// Board
	input wire logic [3:0] btn,
	input wire logic [2:0] sw,
	output logic [3:0] led
);

	logic [datamem_pkg::lane_count-1:0] dm_write;
	logic [datamem_pkg::word_bits-1:0] data_in;
	logic [datamem_pkg::word_addr_bits-1:0] mem_data_addr;
	logic [datamem_pkg::word_bits-1:0] data_out;

	store_unit u_store (
		.exe_store(exe_store),
		.exe_size(exe_size),
		.byte_offset(exe_addr[1:0]),
		.exe_wdata(exe_wdata),
		.dm_write(dm_write),
		.data_in(data_in)
	);

	// Execute word address goes straight to RAM port A
	datamem #(
		.ram_addr_bits(ram_addr_bits)
	) u_datamem (
		.clk(clk),
		.nrst(nrst),
		.dm_write(dm_write),
		.exe_data_addr(exe_addr[datamem_pkg::byte_addr_bits-1:2]),
		.mem_data_addr(mem_data_addr),
		.data_in(data_in),
		.btn(btn),
		.sw(sw),
		.led(led),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.data_out(data_out),
		.con_out(con_out)
	);

	load_unit u_load (
		.clk(clk),
		.nrst(nrst),
		.exe_load(exe_load),
		.exe_addr(exe_addr),
		.exe_size(exe_size),
		.exe_unsigned(exe_unsigned),
		.mem_data_addr(mem_data_addr),
		.data_out(data_out),
		.load_valid(load_valid),
		.load_data(load_data),
		.load_misaligned(load_misaligned)
	);

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic nrst
);

	// 10 ns period
	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Reset low for five rising edges, released on an edge
	initial begin
		nrst = 1'b0;
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== test/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

	localparam int wait_limit = 20;

	logic clk;
	logic nrst;
	logic [12:0] exe_addr;
	logic exe_store;
	logic exe_load;
	logic [1:0] exe_size;
	logic exe_unsigned;
	logic [31:0] exe_wdata;
	logic load_valid;
	logic [31:0] load_data;
	logic load_misaligned;
	logic [3:0] con_write;
	logic [9:0] con_addr;
	logic [31:0] con_in;
	logic [31:0] con_out;
	logic [3:0] btn;
	logic [2:0] sw;
	logic [3:0] led;
	int unsigned seed;

	// Reference copies of the RAM and the LED word
	logic [31:0] model [0:1023];
	logic [31:0] led_word;

	tb_clock clock_gen (.clk(clk), .nrst(nrst));

	mem_subsystem #(.ram_addr_bits(10)) uut (.*);

	// Byte anywhere, half on even offsets, word at offset 0
	function automatic logic legal(input logic [1:0] size, input logic [1:0] off);
		return (size == datamem_pkg::mem_size_byte) ||
			(size == datamem_pkg::mem_size_half && !off[0]) ||
			(size == datamem_pkg::mem_size_word && off == 2'd0);
	endfunction

	// Lane merge of a legal store into an old word
	function automatic logic [31:0] merge(input logic [31:0] old, input logic [1:0] size,
		input logic [1:0] off, input logic [31:0] data);
		logic [31:0] w;
		w = old;
		case (size)
			datamem_pkg::mem_size_byte: w[8*off +: 8] = data[7:0];
			datamem_pkg::mem_size_half: w[8*off +: 16] = data[15:0];
			default: w = data;
		endcase
		return w;
	endfunction

	// Word the DUT should return for a core word address
	function automatic logic [31:0] word_at(input logic [10:0] idx);
		case (idx)
			datamem_pkg::io_btn_addr: return {28'h0, btn};
			datamem_pkg::io_sw_addr: return {29'h0, sw};
			datamem_pkg::io_led_addr: return led_word;
			11'h403: return 32'h0;
			default: return model[idx[9:0]];
		endcase
	endfunction

	// Shift down, then sign or zero extend
	function automatic logic [31:0] extend(input logic [31:0] w, input logic [1:0] size,
		input logic [1:0] off, input logic uns);
		logic [31:0] s;
		s = w >> (8 * off);
		case (size)
			datamem_pkg::mem_size_byte: return uns ? {24'h0, s[7:0]} : {{24{s[7]}}, s[7:0]};
			datamem_pkg::mem_size_half: return uns ? {16'h0, s[15:0]} : {{16{s[15]}}, s[15:0]};
			default: return w;
		endcase
	endfunction

	function automatic logic [9:0] rand_index();
		logic [31:0] r;
		r = $urandom;
		return r[9:0];
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else stop_run($sformatf("error: %s is 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Result is due at the negedge right after the request edge
	task automatic wait_response();
		int n;
		for (n = 0; n < wait_limit; n++) begin
			@(negedge clk);
			if (load_valid || load_misaligned)
				break;
		end
		assert (n < wait_limit) else stop_run("no load response before the timeout");
		assert (n == 0) else stop_run("load response arrived later than one cycle");
	endtask

	task automatic core_store(input logic [12:0] addr, input logic [1:0] size,
		input logic [31:0] data);
		logic [10:0] idx;
		idx = addr[12:2];
		@(posedge clk);
		exe_store <= 1'b1;
		exe_addr <= addr;
		exe_size <= size;
		exe_wdata <= data;
		@(posedge clk);
		exe_store <= 1'b0;
		// Dropped stores leave the model as it is
		if (legal(size, addr[1:0])) begin
			if (idx < datamem_pkg::io_btn_addr)
				model[idx[9:0]] = merge(model[idx[9:0]], size, addr[1:0], data);
			else if (idx == datamem_pkg::io_led_addr)
				led_word = merge(led_word, size, addr[1:0], data);
		end
	endtask

	task automatic load_and_compare(input logic [12:0] addr, input logic [1:0] size,
		input logic uns);
		logic ok;
		logic [31:0] exp;
		@(posedge clk);
		// Inputs changed on the last edge are settled by now
		ok = legal(size, addr[1:0]);
		exp = ok ? extend(word_at(addr[12:2]), size, addr[1:0], uns) : 32'h0;
		exe_load <= 1'b1;
		exe_addr <= addr;
		exe_size <= size;
		exe_unsigned <= uns;
		@(posedge clk);
		exe_load <= 1'b0;
		wait_response();
		compare_value("load_valid", 32'(load_valid), 32'(ok));
		compare_value("load_misaligned", 32'(load_misaligned), 32'(!ok));
		compare_value("load_data", load_data, exp);
	endtask

	task automatic con_store(input logic [9:0] a, input logic [31:0] data);
		@(posedge clk);
		con_write <= 4'hf;
		con_addr <= a;
		con_in <= data;
		@(posedge clk);
		con_write <= 4'h0;
		model[a] = data;
	endtask

	task automatic store_led(input logic [1:0] off, input logic [1:0] size);
		core_store({datamem_pkg::io_led_addr, off}, size, $urandom);
		// LED follows right after the store edge
		@(negedge clk);
		compare_value("led", 32'(led), 32'(led_word[3:0]));
	endtask

	task automatic sub_word_merge();
		logic [9:0] a;
		for (int i = 0; i < 4; i++) begin
			a = rand_index();
			for (int off = 0; off < 4; off++)
				core_store({1'b0, a, 2'(off)}, datamem_pkg::mem_size_byte, $urandom);
			// Half goes to offset 0 and 2 on alternate rounds
			core_store({1'b0, a, 2'(2 * (i % 2))}, datamem_pkg::mem_size_half, $urandom);
			// All legal size, offset and sign combinations
			for (int off = 0; off < 4; off++)
				for (int s = 0; s < 3; s++)
					for (int u = 0; u < 2; u++)
						if (legal(2'(s), 2'(off)))
							load_and_compare({1'b0, a, 2'(off)}, 2'(s), 1'(u));
		end
	endtask

	task automatic misaligned_drop();
		logic [9:0] a;
		a = rand_index();
		core_store({1'b0, a, 2'b01}, datamem_pkg::mem_size_half, $urandom);
		core_store({1'b0, a, 2'b11}, datamem_pkg::mem_size_half, $urandom);
		for (int off = 1; off < 4; off++) begin
			core_store({1'b0, a, 2'(off)}, datamem_pkg::mem_size_word, $urandom);
			load_and_compare({1'b0, a, 2'(off)}, datamem_pkg::mem_size_word, 1'b0);
		end
		load_and_compare({1'b0, a, 2'b11}, datamem_pkg::mem_size_half, 1'b1);
		// Word must be untouched
		load_and_compare({1'b0, a, 2'b00}, datamem_pkg::mem_size_word, 1'b0);
	endtask

	task automatic board_io_regs();
		logic [31:0] r;
		for (int off = 0; off < 4; off++)
			store_led(2'(off), datamem_pkg::mem_size_byte);
		store_led(2'd2, datamem_pkg::mem_size_half);
		store_led(2'd0, datamem_pkg::mem_size_word);
		load_and_compare({datamem_pkg::io_led_addr, 2'b00}, datamem_pkg::mem_size_word, 1'b0);
		for (int i = 0; i < 4; i++) begin
			r = $urandom;
			@(posedge clk);
			btn <= r[3:0];
			sw <= r[6:4];
			load_and_compare({datamem_pkg::io_btn_addr, 2'b00}, datamem_pkg::mem_size_word,
				1'b0);
			load_and_compare({datamem_pkg::io_sw_addr, 2'b00}, datamem_pkg::mem_size_byte,
				1'b0);
		end
		load_and_compare({11'h403, 2'b00}, datamem_pkg::mem_size_word, 1'b0);
	endtask

	task automatic controller_sharing();
		logic [9:0] a;
		for (int i = 0; i < 8; i++) begin
			a = rand_index();
			con_store(a, $urandom);
			load_and_compare({1'b0, a, 2'b00}, datamem_pkg::mem_size_word, 1'b0);
			a = rand_index();
			core_store({1'b0, a, 2'b00}, datamem_pkg::mem_size_word, $urandom);
			@(posedge clk);
			con_addr <= a;
			// Read data one cycle after the address edge
			@(posedge clk);
			@(negedge clk);
			compare_value("con_out", con_out, model[a]);
		end
	endtask

	// Two word loads on consecutive cycles
	task automatic back_to_back_loads();
		logic [9:0] a;
		a = rand_index();
		@(posedge clk);
		exe_load <= 1'b1;
		exe_size <= datamem_pkg::mem_size_word;
		exe_addr <= {1'b0, a, 2'b00};
		@(posedge clk);
		exe_addr <= {1'b0, a + 10'd1, 2'b00};
		wait_response();
		compare_value("load_data", load_data, model[a]);
		@(posedge clk);
		exe_load <= 1'b0;
		wait_response();
		compare_value("load_data", load_data, model[a + 10'd1]);
	endtask

	initial begin
		int n;
		seed = $urandom(32'h64d3_e091);
		exe_addr = '0;
		exe_store = 1'b0;
		exe_load = 1'b0;
		exe_size = '0;
		exe_unsigned = 1'b0;
		exe_wdata = '0;
		con_write = '0;
		con_addr = '0;
		con_in = '0;
		btn = '0;
		sw = '0;
		led_word = '0;
		for (n = 0; n < wait_limit; n++) begin
			@(posedge clk);
			if (nrst)
				break;
		end
		assert (n < wait_limit) else stop_run("reset was never released");
		@(negedge clk);
		compare_value("led", 32'(led), 32'h0);
		compare_value("load_valid", 32'(load_valid), 32'h0);
		compare_value("load_misaligned", 32'(load_misaligned), 32'h0);
		// Known RAM contents through the controller port
		for (int a = 0; a < 1024; a++)
			con_store(10'(a), {10'(a), 2'b01, ~10'(a), 10'(a)});
		for (int i = 0; i < 16; i++) begin
			n = int'(rand_index());
			core_store({1'b0, 10'(n), 2'b00}, datamem_pkg::mem_size_word, $urandom);
			load_and_compare({1'b0, 10'(n), 2'b00}, datamem_pkg::mem_size_word, 1'b0);
		end
		sub_word_merge();
		misaligned_drop();
		board_io_regs();
		controller_sharing();
		back_to_back_loads();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
source/datamem_pkg.sv
source/dp_blockram.sv
source/fpgaio_regs.sv
source/datamem.sv
source/store_unit.sv
source/load_unit.sv
source/mem_subsystem.sv
test/tb_clock.sv
test/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_subsystem -f compile.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0
